/* hw/mips_exec_pkg.sv */
`default_nettype none

package mips_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;

    localparam opcode_t OP_RTYPE  = 6'h00;
    localparam opcode_t OP_REGIMM = 6'h01;
    localparam opcode_t OP_BEQ    = 6'h04;
    localparam opcode_t OP_BNE    = 6'h05;
    localparam opcode_t OP_BLEZ   = 6'h06;
    localparam opcode_t OP_BGTZ   = 6'h07;
    localparam opcode_t OP_ADDI   = 6'h08;
    localparam opcode_t OP_ADDIU  = 6'h09;
    localparam opcode_t OP_SLTI   = 6'h0a;
    localparam opcode_t OP_SLTIU  = 6'h0b;
    localparam opcode_t OP_ANDI   = 6'h0c;
    localparam opcode_t OP_ORI    = 6'h0d;
    localparam opcode_t OP_XORI   = 6'h0e;
    localparam opcode_t OP_LUI    = 6'h0f;
    localparam opcode_t OP_LB     = 6'h20;
    localparam opcode_t OP_LH     = 6'h21;
    localparam opcode_t OP_LW     = 6'h23;
    localparam opcode_t OP_LBU    = 6'h24;
    localparam opcode_t OP_LHU    = 6'h25;
    localparam opcode_t OP_SB     = 6'h28;
    localparam opcode_t OP_SH     = 6'h29;
    localparam opcode_t OP_SW     = 6'h2b;

    localparam funct_t FN_SLL   = 6'd0;
    localparam funct_t FN_SRL   = 6'd2;
    localparam funct_t FN_SRA   = 6'd3;
    localparam funct_t FN_SLLV  = 6'd4;
    localparam funct_t FN_SRLV  = 6'd6;
    localparam funct_t FN_SRAV  = 6'd7;
    localparam funct_t FN_MFHI  = 6'd16;
    localparam funct_t FN_MTHI  = 6'd17;
    localparam funct_t FN_MFLO  = 6'd18;
    localparam funct_t FN_MTLO  = 6'd19;
    localparam funct_t FN_MULT  = 6'd24;
    localparam funct_t FN_MULTU = 6'd25;
    localparam funct_t FN_DIV   = 6'd26;
    localparam funct_t FN_DIVU  = 6'd27;
    localparam funct_t FN_ADD   = 6'd32;
    localparam funct_t FN_ADDU  = 6'd33;
    localparam funct_t FN_SUB   = 6'd34;
    localparam funct_t FN_SUBU  = 6'd35;
    localparam funct_t FN_AND   = 6'd36;
    localparam funct_t FN_OR    = 6'd37;
    localparam funct_t FN_XOR   = 6'd38;
    localparam funct_t FN_NOR   = 6'd39;
    localparam funct_t FN_SLT   = 6'd42;
    localparam funct_t FN_SLTU  = 6'd43;

    // regimm branch selectors in the rt field
    localparam reg_addr_t RT_BLTZ   = 5'd0;
    localparam reg_addr_t RT_BGEZ   = 5'd1;
    localparam reg_addr_t RT_BLTZAL = 5'd16;
    localparam reg_addr_t RT_BGEZAL = 5'd17;

    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX
    } div_state_t;

endpackage

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import mips_exec_pkg::*; (
    input  word_t     instr,
    output opcode_t   opcode,
    output funct_t    funct,
    output reg_addr_t rt,
    output shamt_t    shamt,
    output word_t     imm_ext,
    output logic      is_muldiv,
    output logic      is_mem
);
    imm_t imm;

    assign opcode = instr[31:26];
    assign rt     = instr[20:16];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    // logical immediates are zero extended, everything else sign extended
    always_comb begin
        case (opcode)
            OP_ANDI, OP_ORI, OP_XORI: begin
                imm_ext = {16'h0000, imm};
            end
            default: begin
                imm_ext = {{16{imm[15]}}, imm};
            end
        endcase
    end

    // functions handled by the hi/lo unit
    always_comb begin
        is_muldiv = 1'b0;
        if (opcode == OP_RTYPE) begin
            case (funct)
                FN_MULT, FN_MULTU,
                FN_DIV, FN_DIVU,
                FN_MTHI, FN_MTLO: is_muldiv = 1'b1;
                default:          is_muldiv = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            OP_LB, OP_LH, OP_LW,
            OP_LBU, OP_LHU: begin
                is_mem = 1'b1; // loads
            end
            OP_SB, OP_SH, OP_SW: begin
                is_mem = 1'b1; // stores
            end
            default: begin
                is_mem = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu import mips_exec_pkg::*; (
    input  word_t     op1,           // rs data
    input  word_t     op2,           // rt data
    input  word_t     imm_ext,
    input  word_t     hi,
    input  word_t     lo,
    input  opcode_t   opcode,
    input  funct_t    funct,
    input  reg_addr_t rt,
    input  shamt_t    shamt,
    input  logic      is_mem,
    output word_t     alu_result,
    output logic      alu_b_flag,
    output word_t     alu_mem_addr
);
    logic op1_neg;
    logic op1_zero;

    assign op1_neg  = op1[31];
    assign op1_zero = (op1 == '0);

    // one result per instruction, zero for anything not listed
    always_comb begin
        alu_result = '0;
        alu_b_flag = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_SLL:  alu_result = op2 << shamt;
                    FN_SRL:  alu_result = op2 >> shamt;
                    FN_SRA:  alu_result = word_t'($signed(op2) >>> shamt);
                    FN_SLLV: alu_result = op2 << op1[4:0];
                    FN_SRLV: alu_result = op2 >> op1[4:0];
                    FN_SRAV: alu_result = word_t'($signed(op2) >>> op1[4:0]);
                    FN_MFHI: alu_result = hi;
                    FN_MFLO: alu_result = lo;
                    FN_ADD:  alu_result = op1 + op2;       // no overflow trap
                    FN_ADDU: alu_result = op1 + op2;
                    FN_SUB:  alu_result = op1 - op2;
                    FN_SUBU: alu_result = op1 - op2;
                    FN_AND:  alu_result = op1 & op2;
                    FN_OR:   alu_result = op1 | op2;
                    FN_XOR:  alu_result = op1 ^ op2;
                    FN_NOR:  alu_result = ~(op1 | op2);
                    FN_SLT:  alu_result = word_t'($signed(op1) < $signed(op2));
                    FN_SLTU: alu_result = word_t'(op1 < op2);
                    default: alu_result = '0;           // mult/div/mt* write hi/lo only
                endcase
            end
            OP_REGIMM: begin
                case (rt)
                    RT_BLTZ, RT_BLTZAL: alu_b_flag = op1_neg;
                    RT_BGEZ, RT_BGEZAL: alu_b_flag = !op1_neg;
                    default:            alu_b_flag = 1'b0;
                endcase
            end
            OP_BEQ:   alu_b_flag = (op1 == op2);
            OP_BNE:   alu_b_flag = (op1 != op2);
            OP_BLEZ:  alu_b_flag = op1_neg || op1_zero;
            OP_BGTZ:  alu_b_flag = !op1_neg && !op1_zero;
            OP_ADDI:  alu_result = op1 + imm_ext;
            OP_ADDIU: alu_result = op1 + imm_ext;
            OP_SLTI:  alu_result = word_t'($signed(op1) < $signed(imm_ext));
            OP_SLTIU: alu_result = word_t'(op1 < imm_ext); // sign-extended imm, unsigned compare
            OP_ANDI:  alu_result = op1 & imm_ext;
            OP_ORI:   alu_result = op1 | imm_ext;
            OP_XORI:  alu_result = op1 ^ imm_ext;
            OP_LUI:   alu_result = {imm_ext[15:0], 16'h0000};
            default: begin
                alu_result = '0;
                alu_b_flag = 1'b0;
            end
        endcase
    end

    // effective address for loads and stores
    assign alu_mem_addr = is_mem ? (op1 + imm_ext) : '0;

endmodule

`default_nettype wire

/* hw/muldiv_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit import mips_exec_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,       // issue strobe
    input  logic   is_muldiv,
    input  funct_t funct,
    input  word_t  op1,
    input  word_t  op2,
    output word_t  hi,
    output word_t  lo,
    output logic   busy
);
    div_state_t           state;
    logic [DIV_CNT_W-1:0] step_cnt;
    word_t                rem_q;       // partial remainder
    word_t                quo_q;       // dividend shifts out, quotient shifts in
    word_t                dvs_q;       // divisor magnitude
    logic                 quo_neg;
    logic                 rem_neg;
    logic                 div_signed;
    word_t                mag1;
    word_t                mag2;
    dword_t               prod;
    logic [32:0]          shifted;
    logic                 fits;

    assign div_signed = (funct == FN_DIV);
    assign mag1       = (div_signed && op1[31]) ? -op1 : op1;
    assign mag2       = (div_signed && op2[31]) ? -op2 : op2;

    // 64-bit operands so the low 64 bits hold the full product
    assign prod = (funct == FN_MULT) ? ({{32{op1[31]}}, op1} * {{32{op2[31]}}, op2})
                                     : ({32'h0, op1} * {32'h0, op2});

    // restoring step
    assign shifted = {rem_q, quo_q[31]};
    assign fits    = (shifted >= {1'b0, dvs_q}); // always true for a zero divisor

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= DIV_IDLE;
            busy     <= 1'b0;
            step_cnt <= '0;
            hi       <= '0;
            lo       <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start && is_muldiv) begin
                        case (funct)
                            FN_MULT, FN_MULTU: begin
                                hi <= prod[63:32];
                                lo <= prod[31:0];
                            end
                            FN_MTHI: hi <= op1;
                            FN_MTLO: lo <= op1;
                            FN_DIV, FN_DIVU: begin
                                state    <= DIV_RUN;
                                busy     <= 1'b1;
                                step_cnt <= '0;
                            end
                            default: state <= DIV_IDLE;
                        endcase
                    end
                end
                DIV_RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == DIV_CNT_W'(DIV_STEPS - 1)) begin
                        state <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    hi    <= rem_neg ? -rem_q : rem_q; // remainder follows dividend sign
                    lo    <= quo_neg ? -quo_q : quo_q;
                    state <= DIV_IDLE;
                    busy  <= 1'b0;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && is_muldiv && state == DIV_IDLE) begin
            rem_q   <= '0;
            quo_q   <= mag1;
            dvs_q   <= mag2;
            quo_neg <= div_signed && (op1[31] ^ op2[31]);
            rem_neg <= div_signed && op1[31];
        end else if (state == DIV_RUN) begin
            rem_q <= fits ? (shifted[31:0] - dvs_q) : shifted[31:0];
            quo_q <= {quo_q[30:0], fits};
        end
    end

    // the issuing side has no back-pressure and must wait for a divide to drain
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !start);

    a_idle_not_busy: assert property (@(posedge clk) disable iff (rst)
        (state == DIV_IDLE) |-> !busy);

endmodule

`default_nettype wire

/* hw/mips_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_exec_unit import mips_exec_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  issue,
    input  word_t instr,
    input  word_t op1,
    input  word_t op2,
    output word_t result,
    output logic  result_valid,
    output logic  b_flag,
    output word_t mem_addr,
    output logic  busy
);
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rt;
    shamt_t    shamt;
    word_t     imm_ext;
    logic      is_muldiv;
    logic      is_mem;
    word_t     hi;
    word_t     lo;
    word_t     alu_result;
    logic      alu_b_flag;
    word_t     alu_mem_addr;

    instr_decoder u_dec (
        .instr     (instr),
        .opcode    (opcode),
        .funct     (funct),
        .rt        (rt),
        .shamt     (shamt),
        .imm_ext   (imm_ext),
        .is_muldiv (is_muldiv),
        .is_mem    (is_mem)
    );

    int_alu u_alu (
        .op1          (op1),
        .op2          (op2),
        .imm_ext      (imm_ext),
        .hi           (hi),
        .lo           (lo),
        .opcode       (opcode),
        .funct        (funct),
        .rt           (rt),
        .shamt        (shamt),
        .is_mem       (is_mem),
        .alu_result   (alu_result),
        .alu_b_flag   (alu_b_flag),
        .alu_mem_addr (alu_mem_addr)
    );

    muldiv_unit u_muldiv (
        .clk       (clk),
        .rst       (rst),
        .start     (issue),
        .is_muldiv (is_muldiv),
        .funct     (funct),
        .op1       (op1),
        .op2       (op2),
        .hi        (hi),
        .lo        (lo),
        .busy      (busy)
    );

    // outputs appear one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            result       <= '0;
            result_valid <= 1'b0;
            b_flag       <= 1'b0;
            mem_addr     <= '0;
        end else if (issue) begin
            result       <= alu_result;
            result_valid <= 1'b1;
            b_flag       <= alu_b_flag;
            mem_addr     <= alu_mem_addr;
        end else begin
            result_valid <= 1'b0; // one-cycle pulse, data holds
        end
    end

endmodule

`default_nettype wire

/* dv/tb_mips_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_exec_unit import mips_exec_pkg::*; ();

    localparam int NUM_PATTERNS   = 40;
    localparam int PAT_COLS       = 7;   // instr op1 op2 result b_flag mem_addr wait
    localparam int NUM_RANDOM     = 20;
    localparam int TIMEOUT_CYCLES = (NUM_PATTERNS + NUM_RANDOM) * 40 + 200;

    logic  clk;
    logic  rst;
    logic  issue;
    word_t instr;
    word_t op1;
    word_t op2;
    word_t result;
    logic  result_valid;
    logic  b_flag;
    word_t mem_addr;
    logic  busy;

    word_t  pat_mem [NUM_PATTERNS*PAT_COLS];
    int     err_cnt;
    int     test_cnt;
    int     cycle_cnt;
    integer seed;

    mips_exec_unit dut (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .instr        (instr),
        .op1          (op1),
        .op2          (op2),
        .result       (result),
        .result_valid (result_valid),
        .b_flag       (b_flag),
        .mem_addr     (mem_addr),
        .busy         (busy)
    );

    always #2 clk = ~clk; // 4 ns period

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // one issue, outputs checked on the negedge after the registering edge
    task automatic run_test(input int idx, input word_t t_instr, input word_t a,
                            input word_t b, input word_t exp_res, input logic exp_flag,
                            input word_t exp_addr, input logic wait_busy);
        int errs_before;
        errs_before = err_cnt;
        @(posedge clk);
        issue <= 1'b1;
        instr <= t_instr;
        op1   <= a;
        op2   <= b;
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        check_flag("result_valid", result_valid, 1'b1);
        check_word("result", result, exp_res);
        check_flag("b_flag", b_flag, exp_flag);
        check_word("mem_addr", mem_addr, exp_addr);
        if (wait_busy) begin
            check_flag("busy", busy, 1'b1); // divide in flight
            while (busy) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        check_flag("result_valid", result_valid, 1'b0); // pulse is one cycle wide
        test_cnt++;
        $display("test %0d instr %h %s", idx, t_instr,
                 (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int    p;
        int    k;
        word_t a;
        word_t b;
        word_t rnd;
        word_t exp_res;
        funct_t fn;
        clk      = 1'b0;
        rst      = 1'b1;
        issue    = 1'b0;
        instr    = '0;
        op1      = '0;
        op2      = '0;
        err_cnt  = 0;
        test_cnt = 0;
        seed     = 32'h7b8c_18fb;
        $readmemh("dv/exec_patterns.hex", pat_mem);
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("result_valid", result_valid, 1'b0);
        check_flag("b_flag", b_flag, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_word("result", result, '0);
        check_word("mem_addr", mem_addr, '0);
        $display("reset state checked, errors so far %0d", err_cnt);
        for (p = 0; p < NUM_PATTERNS; p++) begin
            run_test(p, pat_mem[p*PAT_COLS], pat_mem[p*PAT_COLS+1], pat_mem[p*PAT_COLS+2],
                     pat_mem[p*PAT_COLS+3], pat_mem[p*PAT_COLS+4][0],
                     pat_mem[p*PAT_COLS+5], pat_mem[p*PAT_COLS+6][0]);
        end
        // random logic and addu, expected value from the operation itself
        for (k = 0; k < NUM_RANDOM; k++) begin
            a   = $random(seed);
            b   = $random(seed);
            rnd = $random(seed);
            case (rnd % 5)
                0: begin
                    fn      = FN_AND;
                    exp_res = a & b;
                end
                1: begin
                    fn      = FN_OR;
                    exp_res = a | b;
                end
                2: begin
                    fn      = FN_XOR;
                    exp_res = a ^ b;
                end
                3: begin
                    fn      = FN_NOR;
                    exp_res = ~(a | b);
                end
                default: begin
                    fn      = FN_ADDU;
                    exp_res = a + b;
                end
            endcase
            run_test(NUM_PATTERNS + k, {6'h00, 5'd1, 5'd2, 5'd3, 5'd0, fn}, a, b,
                     exp_res, 1'b0, '0, 1'b0);
        end
        $display("tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, tests run %0d, errors %0d",
                 cycle_cnt, test_cnt, err_cnt);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/exec_patterns.hex */
// instr    op1      op2      result   b_flag mem_addr wait
// wait=1 holds the next issue until busy drops
00001810 00000000 00000000 00000000 0 00000000 0
00001812 00000000 00000000 00000000 0 00000000 0
00221821 12345678 11111111 23456789 0 00000000 0
00221822 00000005 00000007 fffffffe 0 00000000 0
00221824 f0f0ff00 0ff00ff0 00f00f00 0 00000000 0
0022182a ffffffff 00000001 00000001 0 00000000 0
00221900 00000000 0000000f 000000f0 0 00000000 0
00221a03 00000000 80000000 ff800000 0 00000000 0
00221807 00000024 f0000000 ff000000 0 00000000 0
2422fffc 00000010 00000000 0000000c 0 00000000 0
2822ffff fffffffe 00000000 00000001 0 00000000 0
2c22ffff 00000005 00000000 00000001 0 00000000 0
3022ff0f ffffffff 00000000 0000ff0f 0 00000000 0
34228001 12340000 00000000 12348001 0 00000000 0
3822ffff ffff0000 00000000 ffffffff 0 00000000 0
3c02beef 00000000 00000000 beef0000 0 00000000 0
10220010 7fffffff 7fffffff 00000000 1 00000000 0
14220010 00000000 ffffffff 00000000 1 00000000 0
18200010 00000000 00000000 00000000 1 00000000 0
1c200010 ffffffff 00000000 00000000 0 00000000 0
04200010 ffffffff 00000000 00000000 1 00000000 0
04210010 00000000 00000000 00000000 1 00000000 0
8c22fff8 00001000 00000000 00000000 0 00000ff8 0
ac220010 80000000 00000000 00000000 0 80000010 0
00220018 fffffffe 00000003 00000000 0 00000000 0
00001810 00000000 00000000 ffffffff 0 00000000 0
00001812 00000000 00000000 fffffffa 0 00000000 0
00220019 ffffffff 00000002 00000000 0 00000000 0
00001810 00000000 00000000 00000001 0 00000000 0
00001812 00000000 00000000 fffffffe 0 00000000 0
00200011 cafef00d 00000000 00000000 0 00000000 0
00200013 0badc0de 00000000 00000000 0 00000000 0
00001810 00000000 00000000 cafef00d 0 00000000 0
00001812 00000000 00000000 0badc0de 0 00000000 0
0022001a ffffff9c 00000007 00000000 0 00000000 1
00001812 00000000 00000000 fffffff2 0 00000000 0
00001810 00000000 00000000 fffffffe 0 00000000 0
0022001b 12345678 00000000 00000000 0 00000000 1
00001812 00000000 00000000 ffffffff 0 00000000 0
00001810 00000000 00000000 12345678 0 00000000 0

/* flist.f */
hw/mips_exec_pkg.sv
hw/instr_decoder.sv
hw/int_alu.sv
hw/muldiv_unit.sv
hw/mips_exec_unit.sv
dv/tb_mips_exec_unit.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
    --top-module tb_mips_exec_unit -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^sim passed$"; then
    exit 0
fi
exit 1
